// ==== verilog/mips_id_pkg.sv ====
package mips_id_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam reg_addr_t NOP_REG = '0;    // destination of a cleared slot

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_PREF    = 6'b110011;

    // function codes of SPECIAL, inst[5:0]
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SYNC = 6'b001111;
    localparam logic [5:0] FN_MFHI = 6'b010000;
    localparam logic [5:0] FN_MFLO = 6'b010010;
    localparam logic [5:0] FN_MTHI = 6'b010001;
    localparam logic [5:0] FN_MTLO = 6'b010011;
    localparam logic [5:0] FN_MOVN = 6'b001011;
    localparam logic [5:0] FN_MOVZ = 6'b001010;

    typedef logic [7:0] aluop_t;
    typedef logic [2:0] alusel_t;

    localparam aluop_t ALUOP_NOP  = 8'b0000_0000;
    localparam aluop_t ALUOP_OR   = 8'b0010_0101;
    localparam aluop_t ALUOP_AND  = 8'b0010_0100;
    localparam aluop_t ALUOP_XOR  = 8'b0010_0110;
    localparam aluop_t ALUOP_NOR  = 8'b0010_0111;
    localparam aluop_t ALUOP_SLL  = 8'b0111_1100;
    localparam aluop_t ALUOP_SRL  = 8'b0000_0010;
    localparam aluop_t ALUOP_SRA  = 8'b0000_0011;
    localparam aluop_t ALUOP_MFHI = 8'b0001_0000;
    localparam aluop_t ALUOP_MFLO = 8'b0001_0010;
    localparam aluop_t ALUOP_MTHI = 8'b0001_0001;
    localparam aluop_t ALUOP_MTLO = 8'b0001_0011;
    localparam aluop_t ALUOP_MOVN = 8'b0000_1011;
    localparam aluop_t ALUOP_MOVZ = 8'b0000_1010;

    localparam alusel_t SEL_NOP   = 3'b000;
    localparam alusel_t SEL_LOGIC = 3'b001;
    localparam alusel_t SEL_SHIFT = 3'b010;
    localparam alusel_t SEL_MOVE  = 3'b011;

    typedef struct packed {
        logic      wreg;    // write pending in that stage
        reg_addr_t wd;
        data_t     wdata;
    } fwd_t;

    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        reg_addr_t wd;
        logic      wreg;
    } id_ctrl_t;

    typedef struct packed {
        id_ctrl_t ctrl;
        data_t    reg1;
        data_t    reg2;
    } id_ex_t;

endpackage

// ==== verilog/operand_fwd.sv ====
`timescale 1ns/1ps

module operand_fwd (
    input  logic                   read_i,       // port read enable from decode
    input  mips_id_pkg::reg_addr_t addr_i,
    input  mips_id_pkg::data_t     rf_data_i,
    input  mips_id_pkg::data_t     imm_i,
    input  mips_id_pkg::fwd_t      ex_fwd_i,     // youngest result
    input  mips_id_pkg::fwd_t      mem_fwd_i,
    output mips_id_pkg::data_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // r0 gets no special treatment here
    assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
    assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;                  // no register read, immediate operand
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.wdata;         // EX wins over MEM
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

// ==== verilog/id_decoder.sv ====
`timescale 1ns/1ps

module id_decoder (
    input  mips_id_pkg::data_t     inst_i,
    input  mips_id_pkg::data_t     reg2_val_i,     // rt operand after forwarding
    output logic                   reg1_read_o,
    output logic                   reg2_read_o,
    output mips_id_pkg::reg_addr_t reg1_addr_o,
    output mips_id_pkg::reg_addr_t reg2_addr_o,
    output mips_id_pkg::data_t     imm_o,
    output mips_id_pkg::id_ctrl_t  ctrl_o
);

    import mips_id_pkg::*;

    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] sa;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    id_ctrl_t   dec;        // control before the movn/movz condition
    logic       is_movn;
    logic       is_movz;

    assign op = inst_i[31:26];
    assign rs = inst_i[25:21];
    assign rt = inst_i[20:16];
    assign rd = inst_i[15:11];
    assign sa = inst_i[10:6];
    assign fn = inst_i[5:0];

    always_comb begin
        dec.aluop   = ALUOP_NOP;
        dec.alusel  = SEL_NOP;
        dec.wd      = rd;
        dec.wreg    = 1'b0;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        reg1_addr_o = rs;
        reg2_addr_o = rt;
        imm_o       = '0;
        is_movn     = 1'b0;
        is_movz     = 1'b0;

        case (op)
            OP_SPECIAL: begin
                if (sa == 5'd0) begin          // R-type needs a zero sa field
                    case (fn)
                        FN_OR, FN_AND, FN_XOR, FN_NOR: begin
                            dec.wreg    = 1'b1;
                            dec.alusel  = SEL_LOGIC;
                            reg1_read_o = 1'b1;
                            reg2_read_o = 1'b1;
                        end
                        FN_SLLV, FN_SRLV, FN_SRAV: begin
                            dec.wreg    = 1'b1;
                            dec.alusel  = SEL_SHIFT;
                            reg1_read_o = 1'b1;    // shift amount from rs
                            reg2_read_o = 1'b1;
                        end
                        FN_SYNC: begin
                            reg2_read_o = 1'b1;    // rt read, value unused
                        end
                        FN_MFHI, FN_MFLO: begin
                            dec.wreg   = 1'b1;
                            dec.alusel = SEL_MOVE;
                        end
                        FN_MTHI, FN_MTLO: begin
                            dec.alusel  = SEL_MOVE;
                            reg1_read_o = 1'b1;
                        end
                        FN_MOVN, FN_MOVZ: begin
                            dec.alusel  = SEL_MOVE;
                            reg1_read_o = 1'b1;
                            reg2_read_o = 1'b1;
                            is_movn     = (fn == FN_MOVN);
                            is_movz     = (fn == FN_MOVZ);
                        end
                        default: begin
                        end
                    endcase

                    case (fn)
                        FN_OR:   dec.aluop = ALUOP_OR;
                        FN_AND:  dec.aluop = ALUOP_AND;
                        FN_XOR:  dec.aluop = ALUOP_XOR;
                        FN_NOR:  dec.aluop = ALUOP_NOR;
                        FN_SLLV: dec.aluop = ALUOP_SLL;
                        FN_SRLV: dec.aluop = ALUOP_SRL;
                        FN_SRAV: dec.aluop = ALUOP_SRA;
                        FN_MFHI: dec.aluop = ALUOP_MFHI;
                        FN_MFLO: dec.aluop = ALUOP_MFLO;
                        FN_MTHI: dec.aluop = ALUOP_MTHI;
                        FN_MTLO: dec.aluop = ALUOP_MTLO;
                        FN_MOVN: dec.aluop = ALUOP_MOVN;
                        FN_MOVZ: dec.aluop = ALUOP_MOVZ;
                        default: dec.aluop = ALUOP_NOP;
                    endcase
                end
            end
            OP_ORI, OP_ANDI, OP_XORI: begin
                dec.wreg    = 1'b1;
                dec.alusel  = SEL_LOGIC;
                dec.wd      = rt;
                reg1_read_o = 1'b1;
                imm_o       = {16'h0, inst_i[15:0]};    // zero extended
                if (op == OP_ORI) begin
                    dec.aluop = ALUOP_OR;
                end else if (op == OP_ANDI) begin
                    dec.aluop = ALUOP_AND;
                end else begin
                    dec.aluop = ALUOP_XOR;
                end
            end
            OP_LUI: begin
                dec.wreg    = 1'b1;
                dec.aluop   = ALUOP_OR;         // rs | (imm << 16)
                dec.alusel  = SEL_LOGIC;
                dec.wd      = rt;
                reg1_read_o = 1'b1;
                imm_o       = {inst_i[15:0], 16'h0};
            end
            OP_PREF: begin
                // prefetch hint, nothing to do in this core
            end
            default: begin
            end
        endcase

        // constant shifts only with opcode and rs both zero
        if (inst_i[31:21] == 11'd0 && (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA)) begin
            dec.wreg    = 1'b1;
            dec.alusel  = SEL_SHIFT;
            dec.wd      = rd;
            reg1_read_o = 1'b0;                 // sa goes in through the immediate
            reg2_read_o = 1'b1;
            imm_o       = {{(DATA_W-5){1'b0}}, sa};
            if (fn == FN_SLL) begin
                dec.aluop = ALUOP_SLL;
            end else if (fn == FN_SRL) begin
                dec.aluop = ALUOP_SRL;
            end else begin
                dec.aluop = ALUOP_SRA;
            end
        end
    end

    // conditional moves look at the forwarded rt value
    always_comb begin
        ctrl_o = dec;
        if (is_movn) begin
            ctrl_o.wreg = (reg2_val_i != '0);
        end else if (is_movz) begin
            ctrl_o.wreg = (reg2_val_i == '0);
        end
    end

endmodule

// ==== verilog/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                clk,
    input  logic                arst_n_i,
    input  mips_id_pkg::id_ex_t d_i,
    output mips_id_pkg::id_ex_t q_o
);

    import mips_id_pkg::*;

    // loads every cycle, no stall input
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o.ctrl.aluop  <= ALUOP_NOP;
            q_o.ctrl.alusel <= SEL_NOP;
            q_o.ctrl.wd     <= NOP_REG;
            q_o.ctrl.wreg   <= 1'b0;      // bubble, nothing written back
            q_o.reg1        <= '0;
            q_o.reg2        <= '0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

// ==== verilog/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  mips_id_pkg::data_t     inst_i,
    input  mips_id_pkg::data_t     reg1_data_i,    // register file port 1
    input  mips_id_pkg::data_t     reg2_data_i,    // register file port 2
    input  mips_id_pkg::fwd_t      ex_fwd_i,
    input  mips_id_pkg::fwd_t      mem_fwd_i,
    output logic                   reg1_read_o,
    output logic                   reg2_read_o,
    output mips_id_pkg::reg_addr_t reg1_addr_o,
    output mips_id_pkg::reg_addr_t reg2_addr_o,
    output mips_id_pkg::id_ex_t    id_ex_o
);

    import mips_id_pkg::*;

    data_t    imm;
    data_t    reg1_val;       // operands after forwarding
    data_t    reg2_val;
    id_ctrl_t ctrl;
    id_ex_t   id_ex_d;

    id_decoder id_decoder_inst (
        .inst_i      (inst_i),
        .reg2_val_i  (reg2_val),      // movn/movz condition
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .imm_o       (imm),
        .ctrl_o      (ctrl)
    );

    operand_fwd fwd1_inst (
        .read_i    (reg1_read_o),
        .addr_i    (reg1_addr_o),
        .rf_data_i (reg1_data_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg1_val)
    );

    operand_fwd fwd2_inst (
        .read_i    (reg2_read_o),
        .addr_i    (reg2_addr_o),
        .rf_data_i (reg2_data_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg2_val)
    );

    // bundle entering the ID/EX register
    assign id_ex_d = {ctrl, reg1_val, reg2_val};

    id_ex_reg id_ex_reg_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .d_i      (id_ex_d),
        .q_o      (id_ex_o)
    );

endmodule

// ==== include/id_ref_model.svh ====
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// one operand by forwarding priority
function automatic mips_id_pkg::data_t forward_operand(
    input logic                   rd,
    input mips_id_pkg::reg_addr_t addr,
    input mips_id_pkg::data_t     rf,
    input mips_id_pkg::data_t     imm,
    input mips_id_pkg::fwd_t      ex_fwd,
    input mips_id_pkg::fwd_t      mem_fwd
);
    if (!rd) return imm;
    if (ex_fwd.wreg && ex_fwd.wd == addr) return ex_fwd.wdata;
    if (mem_fwd.wreg && mem_fwd.wd == addr) return mem_fwd.wdata;
    return rf;
endfunction

// expected ID/EX bundle, read enables and read addresses for one instruction
function automatic mips_id_pkg::id_ex_t expected_id_ex(
    input  mips_id_pkg::data_t     inst,
    input  mips_id_pkg::data_t     rf1,
    input  mips_id_pkg::data_t     rf2,
    input  mips_id_pkg::fwd_t      ex_fwd,
    input  mips_id_pkg::fwd_t      mem_fwd,
    output logic                   rd1,
    output logic                   rd2,
    output mips_id_pkg::reg_addr_t a1,
    output mips_id_pkg::reg_addr_t a2
);
    mips_id_pkg::id_ex_t res;
    mips_id_pkg::data_t  imm;
    logic [5:0]          op;
    logic [5:0]          fn;
    logic                cond;      // movn/movz decoded
    op  = inst[31:26];
    fn  = inst[5:0];
    rd1 = 1'b0;
    rd2 = 1'b0;
    a1  = inst[25:21];
    a2  = inst[20:16];
    imm = '0;
    cond = 1'b0;
    res = '0;
    res.ctrl.wd = inst[15:11];
    if (inst[31:21] == 11'd0 && fn inside {mips_id_pkg::FN_SLL, mips_id_pkg::FN_SRL,
                                           mips_id_pkg::FN_SRA}) begin
        rd2 = 1'b1;
        imm = {27'd0, inst[10:6]};
        res.ctrl = '{aluop: (fn == mips_id_pkg::FN_SLL) ? mips_id_pkg::ALUOP_SLL :
                            (fn == mips_id_pkg::FN_SRL) ? mips_id_pkg::ALUOP_SRL :
                            mips_id_pkg::ALUOP_SRA,
                     alusel: mips_id_pkg::SEL_SHIFT, wd: inst[15:11], wreg: 1'b1};
    end else if (op == mips_id_pkg::OP_SPECIAL && inst[10:6] == 5'd0) begin
        case (fn)
            mips_id_pkg::FN_OR, mips_id_pkg::FN_AND, mips_id_pkg::FN_XOR, mips_id_pkg::FN_NOR,
            mips_id_pkg::FN_MOVN, mips_id_pkg::FN_MOVZ: begin
                rd1 = 1'b1;
                rd2 = 1'b1;
                res.ctrl.aluop = {2'b00, fn};   // these encodings share the function code
                res.ctrl.wreg = 1'b1;
                cond = fn inside {mips_id_pkg::FN_MOVN, mips_id_pkg::FN_MOVZ};
                res.ctrl.alusel = cond ? mips_id_pkg::SEL_MOVE : mips_id_pkg::SEL_LOGIC;
            end
            mips_id_pkg::FN_SLLV, mips_id_pkg::FN_SRLV, mips_id_pkg::FN_SRAV: begin
                rd1 = 1'b1;
                rd2 = 1'b1;
                res.ctrl.wreg = 1'b1;
                res.ctrl.alusel = mips_id_pkg::SEL_SHIFT;
                res.ctrl.aluop = (fn == mips_id_pkg::FN_SLLV) ? mips_id_pkg::ALUOP_SLL :
                                 (fn == mips_id_pkg::FN_SRLV) ? mips_id_pkg::ALUOP_SRL :
                                 mips_id_pkg::ALUOP_SRA;
            end
            mips_id_pkg::FN_MFHI, mips_id_pkg::FN_MFLO,
            mips_id_pkg::FN_MTHI, mips_id_pkg::FN_MTLO: begin
                rd1 = fn inside {mips_id_pkg::FN_MTHI, mips_id_pkg::FN_MTLO};
                res.ctrl.wreg = !rd1;
                res.ctrl.alusel = mips_id_pkg::SEL_MOVE;
                res.ctrl.aluop = {2'b00, fn};
            end
            mips_id_pkg::FN_SYNC: rd2 = 1'b1;
            default: ;
        endcase
    end else if (op inside {mips_id_pkg::OP_ORI, mips_id_pkg::OP_ANDI, mips_id_pkg::OP_XORI,
                            mips_id_pkg::OP_LUI}) begin
        rd1 = 1'b1;
        imm = (op == mips_id_pkg::OP_LUI) ? {inst[15:0], 16'h0} : {16'h0, inst[15:0]};
        res.ctrl = '{aluop: (op == mips_id_pkg::OP_ANDI) ? mips_id_pkg::ALUOP_AND :
                            (op == mips_id_pkg::OP_XORI) ? mips_id_pkg::ALUOP_XOR :
                            mips_id_pkg::ALUOP_OR,
                     alusel: mips_id_pkg::SEL_LOGIC, wd: inst[20:16], wreg: 1'b1};
    end
    res.reg1 = forward_operand(rd1, a1, rf1, imm, ex_fwd, mem_fwd);
    res.reg2 = forward_operand(rd2, a2, rf2, imm, ex_fwd, mem_fwd);
    if (cond) begin
        res.ctrl.wreg = (fn == mips_id_pkg::FN_MOVN) ? (res.reg2 != '0) : (res.reg2 == '0);
    end
    return res;
endfunction

`endif

// ==== test/tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage;

    import mips_id_pkg::*;

    `include "id_ref_model.svh"

    localparam int CYCLE_LIMIT = 2000;       // tests take about 1200 cycles
    localparam int RAND_COUNT  = 1000;
    localparam fwd_t NO_FWD    = '0;

    localparam logic [5:0] R_FNS [7] = '{FN_OR, FN_AND, FN_XOR, FN_NOR,
                                         FN_SLLV, FN_SRLV, FN_SRAV};
    localparam logic [5:0] I_OPS [4] = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI};
    localparam logic [5:0] S_FNS [3] = '{FN_SLL, FN_SRL, FN_SRA};
    localparam logic [5:0] ALL_FNS [17] = '{FN_OR, FN_AND, FN_XOR, FN_NOR, FN_SLLV,
                                            FN_SRLV, FN_SRAV, FN_SLL, FN_SRL, FN_SRA,
                                            FN_SYNC, FN_MFHI, FN_MFLO, FN_MTHI, FN_MTLO,
                                            FN_MOVN, FN_MOVZ};

    logic      clk = 1'b0;
    logic      arst_n_i;
    data_t     inst_i;
    data_t     reg1_data_i;
    data_t     reg2_data_i;
    fwd_t      ex_fwd_i;
    fwd_t      mem_fwd_i;
    logic      reg1_read_o;
    logic      reg2_read_o;
    reg_addr_t reg1_addr_o;
    reg_addr_t reg2_addr_o;
    id_ex_t    id_ex_o;

    logic [31:0] lcg_state;
    int          cycles;
    int          checks;
    int          errors;
    int          errors_at_open;
    int          tests_passed;
    int          tests_failed;
    string       test_name;

    id_ex_t    exp_q;      // expected register content after the next edge
    id_ex_t    now_exp;
    logic      exp_rd1;
    logic      exp_rd2;
    reg_addr_t exp_a1;
    reg_addr_t exp_a2;

    id_stage id_stage_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .inst_i      (inst_i),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .id_ex_o     (id_ex_o)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic id_ex_t cleared_bundle();
        id_ex_t b;
        b.ctrl.aluop  = ALUOP_NOP;
        b.ctrl.alusel = SEL_NOP;
        b.ctrl.wd     = NOP_REG;
        b.ctrl.wreg   = 1'b0;
        b.reg1        = '0;
        b.reg2        = '0;
        return b;
    endfunction

    function automatic data_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic data_t rand_word();
        data_t hi;
        data_t lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[31:16], lo[31:16]};      // low LCG bits have short periods
    endfunction

    function automatic data_t r_type(input logic [5:0] fn, input reg_addr_t rs,
                                     input reg_addr_t rt, input reg_addr_t rd,
                                     input logic [4:0] sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic data_t i_type(input logic [5:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic fwd_t make_fwd(input logic wreg, input reg_addr_t wd,
                                      input data_t wdata);
        fwd_t f;
        f.wreg  = wreg;
        f.wd    = wd;
        f.wdata = wdata;
        return f;
    endfunction

    // mix of valid encodings, odd fields and garbage
    function automatic data_t random_inst();
        data_t w;
        data_t sel;
        w   = rand_word();
        sel = rand_word();
        case (sel[3:0])
            4'd8:    w[31:26] = OP_ORI;
            4'd9:    w[31:26] = OP_ANDI;
            4'd10:   w[31:26] = OP_XORI;
            4'd11:   w[31:26] = OP_LUI;
            4'd12:   w[31:26] = OP_PREF;
            4'd13,
            4'd14,
            4'd15:   ;                          // anything at all
            default: begin
                w[31:26] = OP_SPECIAL;
                w[5:0]   = ALL_FNS[int'(sel[8:4]) % 17];
                if (sel[10:9] != 2'b00) begin
                    w[10:6] = 5'd0;
                end
                if (sel[11]) begin
                    w[25:21] = 5'd0;            // gives the constant shifts a chance
                end
            end
        endcase
        return w;
    endfunction

    // source that often hits one of the instruction's register fields
    function automatic fwd_t random_fwd(input data_t inst);
        data_t     r;
        data_t     d;
        reg_addr_t wd;
        r = rand_word();
        d = rand_word();
        case (r[2:1])
            2'd0:    wd = inst[25:21];
            2'd1:    wd = inst[20:16];
            2'd2:    wd = inst[15:11];
            default: wd = r[10:6];
        endcase
        if (r[5:3] == 3'd0) begin
            d = '0;                             // zero matters for movn/movz
        end
        return make_fwd(r[0], wd, d);
    endfunction

    task automatic apply(input data_t inst, input data_t rf1, input data_t rf2,
                         input fwd_t ex, input fwd_t mem);
        @(posedge clk);
        inst_i      <= inst;
        reg1_data_i <= rf1;
        reg2_data_i <= rf2;
        ex_fwd_i    <= ex;
        mem_fwd_i   <= mem;
    endtask

    task automatic open_test(input string name);
        test_name      = name;
        errors_at_open = errors;
    endtask

    task automatic close_test();
        int n;
        @(posedge clk);
        @(posedge clk);                         // last result checked at the negedge between
        n = errors - errors_at_open;
        if (n == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("test %-34s %s (%0d errors)", test_name, (n == 0) ? "pass" : "fail", n);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("FAILED [%s] %s: got %h, expected %h at %0t", test_name, sig, got, exp,
                 $time);
    endtask

    // inputs change only on rising edges, so the falling edge sees stable values
    always @(negedge clk) begin
        checks++;
        if (id_ex_o.ctrl !== exp_q.ctrl) report_mismatch("id_ex_o.ctrl", 32'(id_ex_o.ctrl),
                                                         32'(exp_q.ctrl));
        if (id_ex_o.reg1 !== exp_q.reg1) report_mismatch("id_ex_o.reg1", id_ex_o.reg1,
                                                         exp_q.reg1);
        if (id_ex_o.reg2 !== exp_q.reg2) report_mismatch("id_ex_o.reg2", id_ex_o.reg2,
                                                         exp_q.reg2);
        now_exp = expected_id_ex(inst_i, reg1_data_i, reg2_data_i, ex_fwd_i, mem_fwd_i,
                                 exp_rd1, exp_rd2, exp_a1, exp_a2);
        if (reg1_read_o !== exp_rd1) report_mismatch("reg1_read_o", 32'(reg1_read_o),
                                                     32'(exp_rd1));
        if (reg2_read_o !== exp_rd2) report_mismatch("reg2_read_o", 32'(reg2_read_o),
                                                     32'(exp_rd2));
        if (reg1_addr_o !== exp_a1) report_mismatch("reg1_addr_o", 32'(reg1_addr_o),
                                                    32'(exp_a1));
        if (reg2_addr_o !== exp_a2) report_mismatch("reg2_addr_o", 32'(reg2_addr_o),
                                                    32'(exp_a2));
        exp_q = arst_n_i ? now_exp : cleared_bundle();
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        data_t w;
        int    k;
        lcg_state   = 32'd31;                   // seed
        arst_n_i    = 1'b0;
        inst_i      = '0;
        reg1_data_i = '0;
        reg2_data_i = '0;
        ex_fwd_i    = NO_FWD;
        mem_fwd_i   = NO_FWD;
        exp_q       = cleared_bundle();

        open_test("reset");
        for (k = 0; k < 8; k++) begin
            apply(r_type(FN_OR, 5'd1, 5'd2, 5'd3, 5'd0), 32'h1111_1111, 32'h2222_2222,
                  make_fwd(1'b1, 5'd1, 32'hdead_beef), NO_FWD);
        end
        @(posedge clk);
        arst_n_i <= 1'b1;
        close_test();

        open_test("r-type logic and variable shifts");
        for (k = 0; k < 7; k++) begin
            repeat (4) begin
                w = rand_word();
                apply(r_type(R_FNS[k], w[4:0], w[9:5], w[14:10], 5'd0), rand_word(),
                      rand_word(), NO_FWD, NO_FWD);
            end
        end
        close_test();

        open_test("immediate forms");
        for (k = 0; k < 4; k++) begin
            repeat (3) begin
                w = rand_word();
                apply(i_type(I_OPS[k], w[4:0], w[9:5], w[31:16]), rand_word(), rand_word(),
                      NO_FWD, NO_FWD);
            end
        end
        for (k = 0; k < 3; k++) begin
            w = rand_word();
            apply(r_type(S_FNS[k], 5'd0, w[9:5], w[14:10], w[19:15]), rand_word(),
                  rand_word(), NO_FWD, NO_FWD);
            apply(r_type(S_FNS[k], w[4:0] | 5'd1, w[9:5], w[14:10], w[19:15]), rand_word(),
                  rand_word(), NO_FWD, NO_FWD);   // nonzero rs, so a nop
        end
        close_test();

        open_test("forwarding priority");
        w = r_type(FN_OR, 5'd5, 5'd6, 5'd3, 5'd0);
        apply(w, 32'ha1a1_a1a1, 32'hb2b2_b2b2, make_fwd(1'b1, 5'd5, 32'h0000_00e5),
              make_fwd(1'b1, 5'd5, 32'h0000_00d5));
        apply(w, 32'ha1a1_a1a1, 32'hb2b2_b2b2, make_fwd(1'b1, 5'd6, 32'h0000_01e6),
              make_fwd(1'b1, 5'd6, 32'h0000_01d6));
        apply(w, 32'ha1a1_a1a1, 32'hb2b2_b2b2, make_fwd(1'b0, 5'd6, 32'h0000_00e6),
              make_fwd(1'b1, 5'd6, 32'h0000_00d6));
        apply(w, 32'ha1a1_a1a1, 32'hb2b2_b2b2, make_fwd(1'b1, 5'd7, 32'h0000_00e7),
              make_fwd(1'b1, 5'd8, 32'h0000_00d8));
        apply(w, 32'ha1a1_a1a1, 32'hb2b2_b2b2, make_fwd(1'b1, 5'd6, 32'h0000_0e06),
              make_fwd(1'b1, 5'd5, 32'h0000_0d05));
        apply(i_type(OP_ORI, 5'd5, 5'd6, 16'h1234), 32'ha1a1_a1a1, 32'hb2b2_b2b2,
              make_fwd(1'b1, 5'd6, 32'hffff_0000), NO_FWD);
        apply(r_type(FN_MFHI, 5'd5, 5'd6, 5'd3, 5'd0), 32'ha1a1_a1a1, 32'hb2b2_b2b2,
              make_fwd(1'b1, 5'd5, 32'hffff_0001), make_fwd(1'b1, 5'd6, 32'h1));
        apply(r_type(FN_SLL, 5'd0, 5'd6, 5'd3, 5'd9), 32'ha1a1_a1a1, 32'hb2b2_b2b2,
              make_fwd(1'b1, 5'd0, 32'h0000_0e00), make_fwd(1'b1, 5'd6, 32'h0000_0d06));
        close_test();

        open_test("moves and nop forms");
        apply(r_type(FN_MOVN, 5'd4, 5'd7, 5'd9, 5'd0), 32'h44, 32'h77, NO_FWD, NO_FWD);
        apply(r_type(FN_MOVN, 5'd4, 5'd7, 5'd9, 5'd0), 32'h44, 32'h0, NO_FWD, NO_FWD);
        apply(r_type(FN_MOVZ, 5'd4, 5'd7, 5'd9, 5'd0), 32'h44, 32'h0, NO_FWD, NO_FWD);
        apply(r_type(FN_MOVZ, 5'd4, 5'd7, 5'd9, 5'd0), 32'h44, 32'h77, NO_FWD, NO_FWD);
        apply(r_type(FN_MOVZ, 5'd4, 5'd7, 5'd9, 5'd0), 32'h44, 32'h77,
              make_fwd(1'b1, 5'd7, 32'h0), NO_FWD);         // forwarded zero wins
        apply(r_type(FN_MOVN, 5'd4, 5'd7, 5'd9, 5'd0), 32'h44, 32'h77, NO_FWD,
              make_fwd(1'b1, 5'd7, 32'h0));
        apply(r_type(FN_MFHI, 5'd4, 5'd7, 5'd9, 5'd0), 32'h44, 32'h77, NO_FWD, NO_FWD);
        apply(r_type(FN_MFLO, 5'd4, 5'd7, 5'd9, 5'd0), 32'h44, 32'h77, NO_FWD, NO_FWD);
        apply(r_type(FN_MTHI, 5'd4, 5'd7, 5'd9, 5'd0), 32'h44, 32'h77, NO_FWD, NO_FWD);
        apply(r_type(FN_MTLO, 5'd4, 5'd7, 5'd9, 5'd0), 32'h44, 32'h77,
              make_fwd(1'b1, 5'd4, 32'h4444), NO_FWD);
        apply(r_type(FN_SYNC, 5'd4, 5'd7, 5'd9, 5'd0), 32'h44, 32'h77, NO_FWD, NO_FWD);
        apply(i_type(OP_PREF, 5'd4, 5'd7, 16'h0010), 32'h44, 32'h77, NO_FWD, NO_FWD);
        close_test();

        open_test("random mix");
        repeat (RAND_COUNT) begin
            w = random_inst();
            apply(w, rand_word(), (rand_word() & 32'h0000_0007) == 0 ? 32'h0 : rand_word(),
                  random_fwd(w), random_fwd(w));
        end
        close_test();

        $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
verilog/mips_id_pkg.sv
verilog/operand_fwd.sv
verilog/id_decoder.sv
verilog/id_ex_reg.sv
verilog/id_stage.sv
test/tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# build the ID stage testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_id_stage -o sim_id_stage \
    && ./obj_dir/sim_id_stage > sim.log \
    ; cat sim.log \
    ; grep -q "Verification passed" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
